/* Makefile */
# Verilator build for the video timing core

VERILATOR ?= verilator
TOP       ?= tb_video_timing
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@status=0; ./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	fi; \
	echo "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* aux/aux_scheduler.sv */
`timescale 1ns/10ps

module aux_scheduler #(
	parameter int AUX_DEPTH = 64
) (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  video_pkg::aux_word_u        aux_word,
	input  logic                        aux_strobe,
	input  logic [video_pkg::CNT_W-1:0] hcnt_raw,
	input  logic                        hblank,
	output logic                        ade,
	output logic [11:0]                 aux_data
);
	import video_pkg::*;

	localparam int PTR_W  = $clog2(AUX_DEPTH);
	localparam int OCC_W  = $clog2(AUX_DEPTH + 1);
	localparam int BEAT_W = $clog2(AUX_LEN);
	// FSM states
	localparam logic [1:0] ST_IDLE   = 2'd0;   // Waiting for a whole group
	localparam logic [1:0] ST_ARMED  = 2'd1;   // Position held, waiting for column
	localparam logic [1:0] ST_ISLAND = 2'd2;

	aux_word_u        buf_mem [AUX_DEPTH];
	aux_word_u        head, pos_q;
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [OCC_W-1:0] occ;
	logic [1:0]       state;
	logic [BEAT_W-1:0] beat;
	logic             full, wr_en, load_pos, start, isl_act, pop;
	logic             ade_s1;
	logic [11:0]      data_s1;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(AUX_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head     = buf_mem[rd_ptr];
	assign full     = (occ == OCC_W'(AUX_DEPTH));
	assign wr_en    = aux_strobe && !full;                  // Dropped when full
	assign load_pos = (state == ST_IDLE) && (occ > OCC_W'(AUX_LEN));
	assign start    = (state == ST_ARMED) && hblank && (hcnt_raw == pos_q.pos.hpos);
	assign isl_act  = start || (state == ST_ISLAND);       // Raw time island
	assign pop      = load_pos || isl_act;

	always_ff @(posedge clk50m_bufg) begin
		if (wr_en)
			buf_mem[wr_ptr] <= aux_word;
		if (load_pos)
			pos_q <= head;
	end

	////////////////////
	// Pointers and FSM
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ    <= '0;
			state  <= ST_IDLE;
			beat   <= '0;
		end else begin
			if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
			if (pop)   rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_en, pop})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
			case (state)
				ST_IDLE:  if (load_pos) state <= ST_ARMED;
				ST_ARMED: if (start) begin
					state <= ST_ISLAND;
					beat  <= BEAT_W'(1);   // Start cycle was beat 0
				end
				ST_ISLAND: if (beat == BEAT_W'(AUX_LEN - 1)) begin
					state <= ST_IDLE;       // Next position read from here
					beat  <= '0;
				end else begin
					beat <= beat + 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Two cycle realign to match the raster outputs
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			ade_s1   <= 1'b0;
			data_s1  <= '0;
			ade      <= 1'b0;
			aux_data <= '0;
		end else begin
			ade_s1   <= isl_act;
			data_s1  <= isl_act ? {head.pld.aux2, head.pld.aux1, head.pld.aux0} : 12'd0;
			ade      <= ade_s1;
			aux_data <= data_s1;
		end
	end

	a_no_overflow: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		aux_strobe |-> !full) else $error("aux write while full: %h", aux_word);
	// Island must sit in the blanking seen two cycles back
	a_ade_in_blank: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		ade |-> $past(hblank, 2)) else $error("ade outside hblank: %h", aux_data);

endmodule

/* common/video_pkg.sv */
package video_pkg;

	// Count and code widths
	localparam int CNT_W  = 11;    // Every h/v count and threshold
	localparam int MODE_W = 4;     // Switch code

	////////////////////
	// Switch codes
	////////////////////
	localparam logic [MODE_W-1:0] MODE_VGA    = 4'b0000;
	localparam logic [MODE_W-1:0] MODE_SVGA   = 4'b0001;
	localparam logic [MODE_W-1:0] MODE_XGA    = 4'b0011;
	localparam logic [MODE_W-1:0] MODE_720P   = 4'b0010;  // Also the fallback
	localparam logic [MODE_W-1:0] MODE_SXGA   = 4'b1000;
	localparam logic [MODE_W-1:0] MODE_CAMERA = 4'b1001;

	// Row index into the timing tables
	localparam int NUM_MODES = 6;
	localparam int IDX_W     = 3;
	localparam logic [IDX_W-1:0] IDX_VGA    = 3'd0;
	localparam logic [IDX_W-1:0] IDX_SVGA   = 3'd1;
	localparam logic [IDX_W-1:0] IDX_XGA    = 3'd2;
	localparam logic [IDX_W-1:0] IDX_720P   = 3'd3;
	localparam logic [IDX_W-1:0] IDX_SXGA   = 3'd4;
	localparam logic [IDX_W-1:0] IDX_CAMERA = 3'd5;

	////////////////////
	// Timing sets
	////////////////////
	// Column order VGA, SVGA, XGA, 720p, SXGA, camera
	localparam logic [CNT_W-1:0] HPIXELS [NUM_MODES] = '{640, 800, 1024, 1280, 1280, 1280};
	localparam logic [CNT_W-1:0] HFRONT  [NUM_MODES] = '{16, 40, 24, 110, 48, 110};
	localparam logic [CNT_W-1:0] HSYNC_W [NUM_MODES] = '{96, 128, 136, 40, 112, 39};
	localparam logic [CNT_W-1:0] HBACK   [NUM_MODES] = '{48, 88, 160, 220, 248, 220};
	localparam logic [CNT_W-1:0] VLINES  [NUM_MODES] = '{480, 600, 768, 720, 1024, 720};
	localparam logic [CNT_W-1:0] VFRONT  [NUM_MODES] = '{10, 1, 3, 5, 1, 4};
	localparam logic [CNT_W-1:0] VSYNC_W [NUM_MODES] = '{2, 4, 6, 5, 3, 4};
	localparam logic [CNT_W-1:0] VBACK   [NUM_MODES] = '{33, 23, 29, 20, 38, 22};
	localparam logic             NEG_POL [NUM_MODES] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

	// Cycles in one aux island
	localparam int AUX_LEN = 32;

	// Position word, leads every island group
	typedef struct packed {
		logic             flag;    // Word kind marker
		logic [CNT_W-1:0] hpos;    // First ade column
	} aux_pos_t;

	// Payload word, one per island cycle
	typedef struct packed {
		logic [3:0] aux2;
		logic [3:0] aux1;
		logic [3:0] aux0;
	} aux_pld_t;

	typedef union packed {
		aux_pos_t pos;
		aux_pld_t pld;
	} aux_word_u;

endpackage

/* common/video_timing_if.sv */
`timescale 1ns/10ps

interface video_timing_if;
	import video_pkg::*;

	// Horizontal thresholds, all inclusive end points
	logic [CNT_W-1:0] hs_blank;    // Last active pixel
	logic [CNT_W-1:0] hs_sync;     // Last front porch pixel
	logic [CNT_W-1:0] he_sync;     // Last sync pixel
	logic [CNT_W-1:0] h_total;     // Wrap point
	// Vertical thresholds
	logic [CNT_W-1:0] vs_blank;
	logic [CNT_W-1:0] vs_sync;
	logic [CNT_W-1:0] ve_sync;
	logic [CNT_W-1:0] v_total;
	logic             neg_pol;     // 1 = active low sync

	modport tbl (output hs_blank, hs_sync, he_sync, h_total,
		vs_blank, vs_sync, ve_sync, v_total, neg_pol);
	modport raster (input hs_blank, hs_sync, he_sync, h_total,
		vs_blank, vs_sync, ve_sync, v_total, neg_pol);

endinterface

/* compile.f */
+incdir+verif
common/video_pkg.sv
common/video_timing_if.sv
hdl/switch_conditioner.sv
hdl/mode_table.sv
timing/raster_counter.sv
aux/aux_scheduler.sv
hdl/video_timing_top.sv
verif/tb_video_timing.sv

/* hdl/mode_table.sv */
`timescale 1ns/10ps

module mode_table (
	input  logic                         clk50m_bufg,
	input  logic                         RSTBTN,
	input  logic [video_pkg::MODE_W-1:0] mode,
	input  logic                         mode_change,
	output logic                         restart,
	video_timing_if.tbl                  tmg
);
	import video_pkg::*;

	logic [IDX_W-1:0] ld_idx;      // Row to load

	// Switch code to table row
	function automatic logic [IDX_W-1:0] mode_to_idx(input logic [MODE_W-1:0] code);
		case (code)
			MODE_VGA:    return IDX_VGA;
			MODE_SVGA:   return IDX_SVGA;
			MODE_XGA:    return IDX_XGA;
			MODE_SXGA:   return IDX_SXGA;
			MODE_CAMERA: return IDX_CAMERA;
			MODE_720P:   return IDX_720P;
			default:     return IDX_720P;  // Unlisted codes
		endcase
	endfunction

	assign ld_idx = RSTBTN ? IDX_VGA : mode_to_idx(mode);  // Reset loads VGA

	////////////////////
	// Threshold registers
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || mode_change) begin
			// Running sums of the porch widths
			tmg.hs_blank <= HPIXELS[ld_idx] - 1'b1;
			tmg.hs_sync  <= HPIXELS[ld_idx] - 1'b1 + HFRONT[ld_idx];
			tmg.he_sync  <= HPIXELS[ld_idx] - 1'b1 + HFRONT[ld_idx] + HSYNC_W[ld_idx];
			tmg.h_total  <= HPIXELS[ld_idx] - 1'b1 + HFRONT[ld_idx] + HSYNC_W[ld_idx]
				+ HBACK[ld_idx];
			tmg.vs_blank <= VLINES[ld_idx] - 1'b1;
			tmg.vs_sync  <= VLINES[ld_idx] - 1'b1 + VFRONT[ld_idx];
			tmg.ve_sync  <= VLINES[ld_idx] - 1'b1 + VFRONT[ld_idx] + VSYNC_W[ld_idx];
			tmg.v_total  <= VLINES[ld_idx] - 1'b1 + VFRONT[ld_idx] + VSYNC_W[ld_idx]
				+ VBACK[ld_idx];
			tmg.neg_pol  <= NEG_POL[ld_idx];
		end
	end

	// Restart lands with the new thresholds
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN)
			restart <= 1'b0;
		else
			restart <= mode_change;
	end

endmodule

/* hdl/switch_conditioner.sv */
`timescale 1ns/10ps

module switch_conditioner #(
	parameter int DEBOUNCE_CYCLES = 500_000
) (
	input  logic                         clk50m_bufg,
	input  logic                         RSTBTN,
	input  logic [video_pkg::MODE_W-1:0] sw,
	output logic [video_pkg::MODE_W-1:0] mode,
	output logic                         mode_change
);
	import video_pkg::*;

	localparam int STAB_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [MODE_W-1:0] sw_meta;     // First synchronizer stage
	logic [MODE_W-1:0] sw_sync;     // Second stage, safe to use
	logic [MODE_W-1:0] cand;        // Code being timed
	logic [STAB_W-1:0] stab_cnt;    // Shared by all four bits

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta     <= MODE_VGA;
			sw_sync     <= MODE_VGA;
			cand        <= MODE_VGA;
			stab_cnt    <= STAB_W'(DEBOUNCE_CYCLES);  // Saturated, nothing pending
			mode        <= MODE_VGA;
			mode_change <= 1'b0;
		end else begin
			sw_meta     <= sw;
			sw_sync     <= sw_meta;
			mode_change <= 1'b0;

			// Any bit moving restarts the window
			if (sw_sync != cand) begin
				cand     <= sw_sync;
				stab_cnt <= '0;
			end else if (stab_cnt != STAB_W'(DEBOUNCE_CYCLES)) begin
				stab_cnt <= stab_cnt + 1'b1;
				// Stable long enough, accept
				if (stab_cnt == STAB_W'(DEBOUNCE_CYCLES - 1) && cand != mode) begin
					mode        <= cand;
					mode_change <= 1'b1;   // Single pulse per accepted change
				end
			end
		end
	end

endmodule

/* hdl/video_timing_top.sv */
`timescale 1ns/10ps

module video_timing_top #(
	parameter int DEBOUNCE_CYCLES = 500_000,   // 10 ms at 50 MHz
	parameter int AUX_DEPTH       = 64
) (
	input  logic                         clk50m_bufg,
	input  logic                         RSTBTN,
	input  logic [video_pkg::MODE_W-1:0] sw,
	input  logic [11:0]                  aux_word,
	input  logic                         aux_strobe,
	output logic [video_pkg::CNT_W-1:0]  hcount,
	output logic [video_pkg::CNT_W-1:0]  vcount,
	output logic                         hsync,
	output logic                         vsync,
	output logic                         de,
	output logic                         ade,
	output logic [11:0]                  aux_data
);
	import video_pkg::*;

	logic [MODE_W-1:0] mode;
	logic              mode_change;
	logic              restart;
	logic [CNT_W-1:0]  hcnt_raw;    // Undelayed column for aux timing
	logic              hblank;

	video_timing_if tmg ();

	////////////////////
	// Mode select
	////////////////////
	switch_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_switch (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.mode        (mode),
		.mode_change (mode_change)
	);

	mode_table u_table (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode        (mode),
		.mode_change (mode_change),
		.restart     (restart),
		.tmg         (tmg.tbl)
	);

	////////////////////
	// Raster and aux
	////////////////////
	raster_counter u_raster (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.restart     (restart),
		.tmg         (tmg.raster),
		.hcount      (hcount),
		.vcount      (vcount),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.hcnt_raw    (hcnt_raw),
		.hblank      (hblank)
	);

	aux_scheduler #(.AUX_DEPTH(AUX_DEPTH)) u_aux (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.aux_word    (aux_word),
		.aux_strobe  (aux_strobe),
		.hcnt_raw    (hcnt_raw),
		.hblank      (hblank),
		.ade         (ade),
		.aux_data    (aux_data)
	);

endmodule

/* timing/raster_counter.sv */
`timescale 1ns/10ps

module raster_counter (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  logic                        restart,
	video_timing_if.raster              tmg,
	output logic [video_pkg::CNT_W-1:0] hcount,
	output logic [video_pkg::CNT_W-1:0] vcount,
	output logic                        hsync,
	output logic                        vsync,
	output logic                        de,
	output logic [video_pkg::CNT_W-1:0] hcnt_raw,
	output logic                        hblank
);
	import video_pkg::*;

	logic [CNT_W-1:0] vcnt_raw;
	logic             vblank;
	logic             hsync_raw;   // Active high before polarity
	logic             vsync_raw;
	// Alignment stage 1
	logic [CNT_W-1:0] hcount_s1;
	logic [CNT_W-1:0] vcount_s1;
	logic             hsync_s1, vsync_s1, de_s1;

	////////////////////
	// Raw counters
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			hcnt_raw <= '0;
			vcnt_raw <= '0;
		end else if (hcnt_raw >= tmg.h_total) begin  // End of line
			hcnt_raw <= '0;
			if (vcnt_raw >= tmg.v_total)
				vcnt_raw <= '0;                         // End of frame
			else
				vcnt_raw <= vcnt_raw + 1'b1;
		end else begin
			hcnt_raw <= hcnt_raw + 1'b1;
		end
	end

	// Blanking and sync windows
	assign hblank    = (hcnt_raw > tmg.hs_blank);
	assign vblank    = (vcnt_raw > tmg.vs_blank);
	assign hsync_raw = (hcnt_raw > tmg.hs_sync) && (hcnt_raw <= tmg.he_sync);
	assign vsync_raw = (vcnt_raw > tmg.vs_sync) && (vcnt_raw <= tmg.ve_sync);

	////////////////////
	// Two stage output alignment
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hcount_s1 <= '0;
			vcount_s1 <= '0;
			hsync_s1  <= 1'b1;   // VGA idle level
			vsync_s1  <= 1'b1;
			de_s1     <= 1'b0;
			hcount    <= '0;
			vcount    <= '0;
			hsync     <= 1'b1;
			vsync     <= 1'b1;
			de        <= 1'b0;
		end else begin
			hcount_s1 <= hcnt_raw;
			vcount_s1 <= vcnt_raw;
			hsync_s1  <= hsync_raw ^ tmg.neg_pol;
			vsync_s1  <= vsync_raw ^ tmg.neg_pol;
			de_s1     <= !hblank && !vblank;
			hcount    <= hcount_s1;
			vcount    <= vcount_s1;
			hsync     <= hsync_s1;
			vsync     <= vsync_s1;
			de        <= de_s1;
		end
	end

	// Output counts stay inside the raster loaded two cycles earlier
	a_count_in_range: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!$past(restart, 2) |-> (hcount <= $past(tmg.h_total, 2))
			&& (vcount <= $past(tmg.v_total, 2)))
		else $error("hcount/vcount past total: %h %h", hcount, vcount);

endmodule

/* verif/tb_mode_expect.svh */
`ifndef TB_MODE_EXPECT_SVH
`define TB_MODE_EXPECT_SVH

// Expected raster per mode, active + front + sync + back
localparam int VGA_ACTIVE  = 640;
localparam int VGA_HSYNC   = 96;              // Active low in VGA
localparam int VGA_LINE    = 640 + 16 + 96 + 48;
localparam int VGA_LINES   = 480 + 10 + 2 + 33;
localparam int SVGA_ACTIVE = 800;
localparam int SVGA_HSYNC  = 128;             // Active high in SVGA
localparam int SVGA_LINE   = 800 + 40 + 128 + 88;
localparam int SVGA_LINES  = 600 + 1 + 4 + 23;

////////////////////
// Continuous checks
////////////////////
// Outputs idle during reset and on the first cycle after it
a_reset_idle: assert property (@(posedge clk50m_bufg)
	(cyc > 1 && $past(RSTBTN)) |-> (!de && !ade && hsync && vsync))
	else begin
		check_errs++;
		$display("FAIL reset idle: de %h ade %h hsync %h vsync %h", de, ade, hsync, vsync);
	end

// Any break in the column sequence lands on 0
a_hcount_step: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
	(hcount != $past(hcount) + 1'b1) |-> (hcount == '0))
	else begin
		check_errs++;
		$display("FAIL hcount: got %h after %h", hcount, $past(hcount));
	end

a_island_no_de: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
	ade |-> !de)
	else begin
		check_errs++;
		$display("FAIL de: got %h during ade", de);
	end

// Incomplete aux group, island must stay off
a_no_early_island: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
	island_locked |-> !ade)
	else begin
		check_errs++;
		$display("FAIL ade: got %h expected 0", ade);
	end

`endif

/* verif/tb_video_timing.sv */
`timescale 1ns/10ps

module tb_video_timing;
	import video_pkg::*;

	localparam int DEB = 16;    // Short debounce window
	// Selectors for wait_events
	localparam int EV_HS  = 0;
	localparam int EV_DE  = 1;
	localparam int EV_VS  = 2;
	localparam int EV_RST = 3;
	localparam int EV_ISL = 4;

	logic              clk50m_bufg;
	logic              RSTBTN;
	logic [MODE_W-1:0] sw;
	logic [11:0]       aux_word;
	logic              aux_strobe;
	logic [CNT_W-1:0]  hcount, vcount;
	logic              hsync, vsync, de, ade;
	logic [11:0]       aux_data;

	int               check_errs, timeout_errs, cyc;
	bit               timed_out;
	bit               island_locked;   // Aux group still short
	int               run_len, hi_run, lo_run, de_len, de_run, vs_len, vs_period, ade_len;
	int               hs_edges, de_falls, vs_rises, restarts, islands;
	logic             hs_prev, de_prev, vs_prev, ade_prev;
	logic [CNT_W-1:0] hc_prev, rs_vcount, line_end, exp_pos;
	logic [11:0]      exp_q [$];       // Payloads in write order

	`include "tb_mode_expect.svh"

	video_timing_top #(.DEBOUNCE_CYCLES(DEB), .AUX_DEPTH(64)) uut (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.aux_word    (aux_word),
		.aux_strobe  (aux_strobe),
		.hcount      (hcount),
		.vcount      (vcount),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.ade         (ade),
		.aux_data    (aux_data)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;   // 50 MHz
	end

	////////////////////
	// Output monitor
	////////////////////
	always @(posedge clk50m_bufg) begin : monitor
		logic [11:0] exp_word;
		cyc      <= cyc + 1;
		hs_prev  <= hsync;
		de_prev  <= de;
		vs_prev  <= vsync;
		ade_prev <= ade;
		hc_prev  <= hcount;
		if (!RSTBTN) begin
			if (hsync != hs_prev) begin   // Close the run of the old level
				if (hs_prev)
					hi_run <= run_len;
				else
					lo_run <= run_len;
				run_len  <= 1;
				hs_edges <= hs_edges + 1;
			end else begin
				run_len <= run_len + 1;
			end
			de_len <= de ? de_len + 1 : 0;
			if (de_prev && !de) begin
				de_run   <= de_len;
				de_falls <= de_falls + 1;
			end
			vs_len <= vs_len + 1;
			if (vsync && !vs_prev) begin   // Rising edge to rising edge
				vs_period <= vs_len;
				vs_len    <= 1;
				vs_rises  <= vs_rises + 1;
			end
			// Jump to 0 that is not a line wrap
			if (hcount == '0 && hc_prev != '0 && hc_prev != line_end) begin
				restarts  <= restarts + 1;
				rs_vcount <= vcount;
			end
			ade_len <= ade ? ade_len + 1 : 0;
			if (ade && !ade_prev)
				assert (hcount == exp_pos) else begin
					check_errs++;
					$display("FAIL hcount at island start: got %h expected %h", hcount, exp_pos);
				end
			if (ade) begin
				if (exp_q.size() == 0) begin
					check_errs++;
					$display("ade was high with no payload word pending");
				end else begin
					exp_word = exp_q.pop_front();
					assert (aux_data == exp_word) else begin
						check_errs++;
						$display("FAIL aux_data: got %h expected %h", aux_data, exp_word);
					end
				end
			end
			if (!ade && ade_prev) begin
				assert (ade_len == AUX_LEN) else begin
					check_errs++;
					$display("FAIL ade run: got %h expected %h", ade_len, AUX_LEN);
				end
				islands <= islands + 1;
			end
		end
	end

	function automatic int event_count(input int which);
		case (which)
			EV_HS:   return hs_edges;
			EV_DE:   return de_falls;
			EV_VS:   return vs_rises;
			EV_RST:  return restarts;
			default: return islands;
		endcase
	endfunction

	task automatic wait_events(input int which, input int n, input int limit, input string what);
		int start;
		int waited;
		start  = event_count(which);
		waited = 0;
		while (event_count(which) < start + n && waited < limit) begin
			@(posedge clk50m_bufg);
			waited++;
		end
		if (event_count(which) < start + n) begin
			timed_out = 1'b1;
			timeout_errs++;
			$display("Timed out waiting for %s", what);
		end
	endtask

	task automatic wait_column(input int col);
		int waited;
		waited = 0;
		while (hcount != CNT_W'(col) && waited < 4 * SVGA_LINE) begin
			@(posedge clk50m_bufg);
			waited++;
		end
		if (hcount != CNT_W'(col)) begin
			timed_out = 1'b1;
			timeout_errs++;
			$display("Timed out waiting for column %0d", col);
		end
	endtask

	// Line length, sync width on the active level, de width
	task automatic check_line(input string name, input int len, input int sync_w, input int act,
		input bit neg);
		int sync_meas;
		wait_events(EV_HS, 5, 6 * len, {name, " hsync edges"});
		wait_events(EV_DE, 2, 64 * len, {name, " de lines"});
		if (timed_out)
			return;
		sync_meas = neg ? lo_run : hi_run;
		assert (hi_run + lo_run == len) else begin
			check_errs++;
			$display("FAIL %s hsync period: got %h expected %h", name, hi_run + lo_run, len);
		end
		assert (sync_meas == sync_w) else begin
			check_errs++;
			$display("FAIL %s hsync width: got %h expected %h", name, sync_meas, sync_w);
		end
		assert (de_run == act) else begin
			check_errs++;
			$display("FAIL %s de: got %h expected %h", name, de_run, act);
		end
	endtask

	task automatic write_aux(input logic [11:0] w, input bit payload);
		@(posedge clk50m_bufg);
		aux_word   <= w;
		aux_strobe <= 1'b1;
		if (payload)
			exp_q.push_back(w);
	endtask

	task automatic stop_aux();
		@(posedge clk50m_bufg);
		aux_strobe <= 1'b0;
	endtask

	////////////////////
	// Test sequence
	////////////////////
	task automatic run_tests();
		int pos;
		int rst_before;
		int line;
		check_line("VGA", VGA_LINE, VGA_HSYNC, VGA_ACTIVE, 1'b1);
		wait_events(EV_VS, 2, 3 * VGA_LINE * VGA_LINES, "VGA frame");
		if (timed_out)
			return;
		line = hi_run + lo_run;
		assert (vs_period % line == 0 && vs_period / line == VGA_LINES) else begin
			check_errs++;
			$display("FAIL vsync period: got %h expected %h", vs_period, VGA_LINE * VGA_LINES);
		end
		// Mode switch part way along a line
		wait_column(100);
		if (timed_out)
			return;
		sw <= MODE_SVGA;
		wait_events(EV_RST, 1, 4 * DEB + 64, "raster restart");
		if (timed_out)
			return;
		assert (rs_vcount == '0) else begin
			check_errs++;
			$display("FAIL vcount at restart: got %h expected 0", rs_vcount);
		end
		line_end <= CNT_W'(SVGA_LINE - 1);
		check_line("SVGA", SVGA_LINE, SVGA_HSYNC, SVGA_ACTIVE, 1'b0);
		if (timed_out)
			return;
		// Glitch shorter than the debounce window
		rst_before = restarts;
		sw <= MODE_VGA;
		repeat (DEB / 2) @(posedge clk50m_bufg);
		sw <= MODE_SVGA;
		check_line("SVGA glitch", SVGA_LINE, SVGA_HSYNC, SVGA_ACTIVE, 1'b0);
		if (timed_out)
			return;
		assert (restarts == rst_before) else begin
			check_errs++;
			$display("A short switch glitch restarted the raster");
		end
		// Position inside blanking so the island ends by the line wrap
		pos     = SVGA_ACTIVE + int'($urandom % (SVGA_LINE - SVGA_ACTIVE - AUX_LEN + 1));
		exp_pos = CNT_W'(pos);
		write_aux({1'b1, CNT_W'(pos)}, 1'b0);
		for (int i = 0; i < AUX_LEN - 1; i++)
			write_aux(12'($urandom), 1'b1);
		stop_aux();
		wait_events(EV_VS, 3, 4 * SVGA_LINE * SVGA_LINES, "two frames with a short group");
		if (timed_out)
			return;
		island_locked <= 1'b0;
		write_aux(12'($urandom), 1'b1);   // Completes the group
		stop_aux();
		wait_events(EV_ISL, 1, 4 * SVGA_LINE, "aux island");
		if (timed_out)
			return;
		assert (islands == 1) else begin
			check_errs++;
			$display("FAIL islands: got %h expected %h", islands, 1);
		end
		assert (exp_q.size() == 0) else begin
			check_errs++;
			$display("FAIL exp_q size: got %h expected 0", exp_q.size());
		end
	endtask

	task automatic end_run();
		$display("Errors: checks %0d, timeouts %0d", check_errs, timeout_errs);
		if (check_errs == 0 && timeout_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	initial begin
		void'($urandom(32'hdfbb));
		RSTBTN        = 1'b1;
		sw            = MODE_VGA;
		aux_word      = '0;
		aux_strobe    = 1'b0;
		island_locked = 1'b1;
		line_end      = CNT_W'(VGA_LINE - 1);
		exp_pos       = '0;
		hs_prev       = 1'b1;
		vs_prev       = 1'b1;
		repeat (16) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
		run_tests();
		end_run();
	end

endmodule
